/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DMA to SRAM testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module dma_sram_tb -o dma_sram_sim > build.log 2>&1 \
    && ./obj_dir/dma_sram_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
echo "Simulation passed"
exit 0

/* src/dma_req_queue.sv */
`timescale 1ns/1ps

module dma_req_queue (
    input  logic                 core_clk,
    input  logic                 rst_n,

    input  logic                 req_valid,
    input  logic                 req_write,
    input  dma_types_pkg::addr_t req_addr,
    input  dma_types_pkg::data_t req_wdata,
    input  dma_types_pkg::strb_t req_strb,

    input  logic                 head_pop,
    output logic                 head_valid,
    output logic                 head_write,
    output dma_types_pkg::addr_t head_addr,
    output dma_types_pkg::data_t head_wdata,
    output dma_types_pkg::strb_t head_strb,

    output logic                 credit_return
);
    import dma_types_pkg::*;

    // Entry payload
    logic  write_q [QUEUE_DEPTH];
    addr_t addr_q  [QUEUE_DEPTH];
    data_t wdata_q [QUEUE_DEPTH];
    strb_t strb_q  [QUEUE_DEPTH];

    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;
    queue_cnt_t count;

    logic push;
    logic pop;
    logic full;

    // No ready on the request side, every valid cycle is a push
    assign push = req_valid;
    assign pop  = head_pop & head_valid;
    assign full = (count == QUEUE_CNT_W'(QUEUE_DEPTH));

    always_ff @(posedge core_clk) begin
        if (push) begin
            write_q[wr_ptr] <= req_write;
            addr_q[wr_ptr]  <= req_addr;
            wdata_q[wr_ptr] <= req_wdata;
            strb_q[wr_ptr]  <= req_strb;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per freed entry
            credit_return <= pop;
        end
    end

    assign head_valid = (count != '0);
    assign head_write = write_q[rd_ptr];
    assign head_addr  = addr_q[rd_ptr];
    assign head_wdata = wdata_q[rd_ptr];
    assign head_strb  = strb_q[rd_ptr];

    // Requester spent a credit it did not hold
    a_no_push_when_full: assert property (
        @(posedge core_clk) disable iff (!rst_n) req_valid |-> !full
    );

    // Decoder must only pop a valid head
    a_no_pop_when_empty: assert property (
        @(posedge core_clk) disable iff (!rst_n) head_pop |-> head_valid
    );

endmodule

/* src/dma_sram_top.sv */
`timescale 1ns/1ps

module dma_sram_top (
    input  logic                 core_clk,
    input  logic                 rst_n,

    input  logic                 req_valid,
    input  logic                 req_write,
    input  dma_types_pkg::addr_t req_addr,
    input  dma_types_pkg::data_t req_wdata,
    input  dma_types_pkg::strb_t req_strb,
    output logic                 credit_return,

    output logic                 rsp_valid,
    output logic                 rsp_write,
    output logic                 rsp_err,
    output dma_types_pkg::data_t rsp_rdata
);
    import dma_types_pkg::*;
    import sram_map_pkg::*;

    // Queue head
    logic  head_valid;
    logic  head_write;
    addr_t head_addr;
    data_t head_wdata;
    strb_t head_strb;
    logic  head_pop;

    // SRAM port
    logic        sram_en;
    logic        sram_we;
    sram_index_t sram_index;
    data_t       sram_wdata;
    strb_t       sram_strb;
    data_t       sram_rdata;

    dma_req_queue dma_req_queue_i (
        .core_clk      (core_clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_strb      (req_strb),
        .head_pop      (head_pop),
        .head_valid    (head_valid),
        .head_write    (head_write),
        .head_addr     (head_addr),
        .head_wdata    (head_wdata),
        .head_strb     (head_strb),
        .credit_return (credit_return)
    );

    sram_window_decoder sram_window_decoder_i (
        .core_clk   (core_clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_write (head_write),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_strb  (head_strb),
        .head_pop   (head_pop),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_index (sram_index),
        .sram_wdata (sram_wdata),
        .sram_strb  (sram_strb),
        .sram_rdata (sram_rdata),
        .rsp_valid  (rsp_valid),
        .rsp_write  (rsp_write),
        .rsp_err    (rsp_err),
        .rsp_rdata  (rsp_rdata)
    );

    sram_responder sram_responder_i (
        .core_clk   (core_clk),
        .sram_en    (sram_en),
        .sram_we    (sram_we),
        .sram_index (sram_index),
        .sram_wdata (sram_wdata),
        .sram_strb  (sram_strb),
        .sram_rdata (sram_rdata)
    );

endmodule

/* src/dma_types_pkg.sv */
package dma_types_pkg;

    // Request and response word geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int STRB_W     = DATA_W / BYTE_W;
    localparam int BYTE_OFF_W = $clog2(STRB_W);

    // Request queue sizing, also the credit count after reset
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [DATA_W-1:0] data_t;

    // Byte enables, one per byte of data_t
    typedef logic [STRB_W-1:0] strb_t;

    typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
    typedef logic [QUEUE_CNT_W-1:0] queue_cnt_t;

endpackage

/* src/sram_map_pkg.sv */
package sram_map_pkg;

    // SRAM size in words
    localparam int SRAM_WORDS   = 1024;
    localparam int SRAM_INDEX_W = $clog2(SRAM_WORDS);

    // Byte address bits that fall inside the window
    localparam int SRAM_ADDR_W = 12;

    // Window base, only bits above SRAM_ADDR_W take part in the compare
    localparam logic [31:0] SRAM_BASE_ADDR = 32'h2000_0000;

    // Word index into the SRAM
    typedef logic [SRAM_INDEX_W-1:0] sram_index_t;

endpackage

/* src/sram_responder.sv */
`timescale 1ns/1ps

module sram_responder (
    input  logic                      core_clk,

    input  logic                      sram_en,
    input  logic                      sram_we,
    input  sram_map_pkg::sram_index_t sram_index,
    input  dma_types_pkg::data_t      sram_wdata,
    input  dma_types_pkg::strb_t      sram_strb,
    output dma_types_pkg::data_t      sram_rdata
);
    import dma_types_pkg::*;
    import sram_map_pkg::*;

    // Word storage, contents start unknown
    data_t mem [SRAM_WORDS];

    // Byte-masked write
    always_ff @(posedge core_clk) begin
        if (sram_en && sram_we) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (sram_strb[b]) begin
                    mem[sram_index][b*BYTE_W +: BYTE_W] <= sram_wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // Read data is valid the cycle after the access
    always_ff @(posedge core_clk) begin
        if (sram_en && !sram_we) begin
            sram_rdata <= mem[sram_index];
        end
    end

endmodule

/* src/sram_window_decoder.sv */
`timescale 1ns/1ps

module sram_window_decoder (
    input  logic                      core_clk,
    input  logic                      rst_n,

    input  logic                      head_valid,
    input  logic                      head_write,
    input  dma_types_pkg::addr_t      head_addr,
    input  dma_types_pkg::data_t      head_wdata,
    input  dma_types_pkg::strb_t      head_strb,
    output logic                      head_pop,

    output logic                      sram_en,
    output logic                      sram_we,
    output sram_map_pkg::sram_index_t sram_index,
    output dma_types_pkg::data_t      sram_wdata,
    output dma_types_pkg::strb_t      sram_strb,
    input  dma_types_pkg::data_t      sram_rdata,

    output logic                      rsp_valid,
    output logic                      rsp_write,
    output logic                      rsp_err,
    output dma_types_pkg::data_t      rsp_rdata
);
    import dma_types_pkg::*;
    import sram_map_pkg::*;

    logic hit;
    logic pend_valid;
    logic pend_write;
    logic pend_err;

    // Window match on the bits above the in-window offset
    assign hit = (head_addr[ADDR_W-1:SRAM_ADDR_W] == SRAM_BASE_ADDR[ADDR_W-1:SRAM_ADDR_W]);

    // SRAM takes one access per cycle, so the head never waits
    assign head_pop = head_valid;

    assign sram_en    = head_valid & hit;
    assign sram_we    = head_write;
    assign sram_index = head_addr[SRAM_ADDR_W-1:BYTE_OFF_W];
    assign sram_wdata = head_wdata;
    assign sram_strb  = head_strb;

    // Side pipeline, lines up with the registered SRAM read
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
            pend_write <= 1'b0;
            pend_err   <= 1'b0;
        end else begin
            pend_valid <= head_valid;
            pend_write <= head_valid & head_write;
            pend_err   <= head_valid & ~hit;
        end
    end

    assign rsp_valid = pend_valid;
    assign rsp_write = pend_write;
    assign rsp_err   = pend_err;

    // Only a clean read returns SRAM data
    assign rsp_rdata = (pend_valid && !pend_write && !pend_err) ? sram_rdata : '0;

    // A miss never reached the SRAM
    a_err_without_access: assert property (
        @(posedge core_clk) disable iff (!rst_n) rsp_err |-> !$past(sram_en)
    );

endmodule

/* tb/dma_sram_tb.sv */
`timescale 1ns/1ps

module dma_sram_tb;
    import dma_types_pkg::*;
    import sram_map_pkg::*;

    localparam logic [19:0] HIT_TAG = 20'h20000;
    localparam int CREDIT_TIMEOUT  = 100;
    localparam int DRAIN_TIMEOUT   = 200;
    localparam int LATENCY_TIMEOUT = 20;
    localparam int RANDOM_REQS     = 300;

    logic  core_clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    data_t req_wdata;
    strb_t req_strb;
    logic  credit_return;
    logic  rsp_valid;
    logic  rsp_write;
    logic  rsp_err;
    data_t rsp_rdata;

    int errors;
    int credits;
    int credit_pulses;
    int req_count;
    int rsp_count;
    int last_wait;

    // Expected responses in issue order
    logic  exp_write_q [$];
    logic  exp_err_q   [$];
    data_t exp_rdata_q [$];

    // Model memory and the bytes written so far, by word index
    data_t model_mem [int];
    strb_t byte_mask [int];
    int    full_words [$];

    dma_sram_top dma_sram_top_i (
        .core_clk      (core_clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_strb      (req_strb),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_write     (rsp_write),
        .rsp_err       (rsp_err),
        .rsp_rdata     (rsp_rdata)
    );

    always #5 core_clk = ~core_clk;

    function automatic void ref_response(input logic write, input addr_t addr,
                                         input data_t wdata, input strb_t strb,
                                         output logic exp_err, output data_t exp_rdata);
        int    idx;
        data_t word;
        exp_err   = (addr[31:12] != HIT_TAG);
        exp_rdata = '0;
        if (!exp_err) begin
            idx  = int'(addr[11:2]);
            word = model_mem.exists(idx) ? model_mem[idx] : '0;
            if (write) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        word[b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
                model_mem[idx] = word;
            end else begin
                exp_rdata = word;
            end
        end
    endfunction

    task automatic check_value(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("Error: %s actual 0x%h expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic end_run();
        $display("Errors: %0d, requests: %0d, responses: %0d, credit pulses: %0d",
                 errors, req_count, rsp_count, credit_pulses);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Advance one cycle and collect a returned credit
    task automatic step_cycle();
        @(posedge core_clk);
        #1;
        if (credit_return) begin
            credits++;
        end
        if (credits < 0 || credits > QUEUE_DEPTH) begin
            $display("Credit count %0d left the range 0 to %0d", credits, QUEUE_DEPTH);
            errors++;
        end
    endtask

    // Words count as readable once every byte has been written
    task automatic track_written(input logic write, input addr_t addr, input strb_t strb);
        int idx;
        idx = int'(addr[11:2]);
        if (write && addr[31:12] == HIT_TAG) begin
            if (!byte_mask.exists(idx)) begin
                byte_mask[idx] = '0;
            end
            if (byte_mask[idx] != 4'hf) begin
                byte_mask[idx] = byte_mask[idx] | strb;
                if (byte_mask[idx] == 4'hf) begin
                    full_words.push_back(idx);
                end
            end
        end
    endtask

    task automatic issue_request(input logic write, input addr_t addr,
                                 input data_t wdata, input strb_t strb);
        logic  exp_err;
        data_t exp_rdata;
        last_wait = 0;
        while (credits == 0 && last_wait < CREDIT_TIMEOUT) begin
            step_cycle();
            last_wait++;
        end
        if (credits == 0) begin
            $display("Timed out waiting for a credit");
            errors++;
            end_run();
        end else begin
            ref_response(write, addr, wdata, strb, exp_err, exp_rdata);
            exp_write_q.push_back(write);
            exp_err_q.push_back(exp_err);
            exp_rdata_q.push_back(exp_rdata);
            track_written(write, addr, strb);
            req_valid = 1'b1;
            req_write = write;
            req_addr  = addr;
            req_wdata = wdata;
            req_strb  = strb;
            credits--;
            req_count++;
            step_cycle();
            req_valid = 1'b0;
        end
    endtask

    task automatic drain_responses();
        int cycles;
        cycles = 0;
        while (exp_write_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (exp_write_q.size() != 0) begin
            $display("Timed out with %0d responses still missing", exp_write_q.size());
            errors++;
            end_run();
        end else begin
            step_cycle();
            step_cycle();
        end
    endtask

    // Empty queue, so the response follows two cycles after the request
    task automatic check_latency(input addr_t addr);
        int cycles;
        issue_request(1'b0, addr, '0, 4'hf);
        cycles = 1;
        while (!rsp_valid && cycles < LATENCY_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        check_value("rsp_valid latency", data_t'(cycles), data_t'(2));
    endtask

    always @(negedge core_clk) begin
        if (rst_n) begin
            if (credit_return) begin
                credit_pulses++;
            end
            if (rsp_valid) begin
                rsp_count++;
                if (exp_write_q.size() == 0) begin
                    $display("A response arrived with no request outstanding");
                    errors++;
                end else begin
                    check_value("rsp_write", data_t'(rsp_write), data_t'(exp_write_q.pop_front()));
                    check_value("rsp_err", data_t'(rsp_err), data_t'(exp_err_q.pop_front()));
                    check_value("rsp_rdata", rsp_rdata, exp_rdata_q.pop_front());
                end
            end
        end
    end

    initial begin
        logic  write;
        addr_t addr;
        int    idx;
        core_clk      = 1'b0;
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_wdata     = '0;
        req_strb      = '0;
        errors        = 0;
        credit_pulses = 0;
        req_count     = 0;
        rsp_count     = 0;
        last_wait     = 0;
        credits       = QUEUE_DEPTH;
        void'($urandom(75));
        repeat (10) @(posedge core_clk);
        #1;
        rst_n = 1'b1;

        // Full-word write, then read back
        issue_request(1'b1, 32'h2000_0010, 32'hdead_beef, 4'hf);
        issue_request(1'b0, 32'h2000_0010, '0, 4'hf);
        drain_responses();
        check_latency(32'h2000_0010);
        drain_responses();

        // Byte merge on one word
        issue_request(1'b1, 32'h2000_0020, 32'h1122_3344, 4'hf);
        issue_request(1'b1, 32'h2000_0020, 32'haabb_ccdd, 4'b0101);
        issue_request(1'b1, 32'h2000_0020, 32'h5566_7788, 4'b1000);
        issue_request(1'b0, 32'h2000_0020, '0, 4'hf);

        // Misses with the same in-window offset must leave the SRAM alone
        issue_request(1'b1, 32'h3000_0010, 32'h0bad_f00d, 4'hf);
        issue_request(1'b0, 32'h1000_0010, '0, 4'hf);
        issue_request(1'b0, 32'h2000_0010, '0, 4'hf);
        drain_responses();

        // Four back-to-back requests on a full credit pool
        for (int i = 0; i < 4; i++) begin
            issue_request(i[0], 32'h2000_0010, 32'h0101_0101 * i, 4'hf);
            check_value("credit wait cycles", data_t'(last_wait), '0);
        end
        drain_responses();

        for (int i = 0; i < RANDOM_REQS; i++) begin
            repeat ($urandom_range(0, 3)) step_cycle();
            write = (full_words.size() == 0) || ($urandom_range(0, 1) == 1);
            if ($urandom_range(0, 1) == 1) begin
                if (write) begin
                    idx = int'($urandom_range(0, 63));
                end else begin
                    idx = full_words[$urandom_range(0, full_words.size() - 1)];
                end
                addr = {HIT_TAG, sram_index_t'(idx), 2'b00};
            end else begin
                addr = $urandom;
                if (addr[31:12] == HIT_TAG) begin
                    addr[31] = 1'b1;
                end
            end
            issue_request(write, addr, write ? data_t'($urandom) : '0, strb_t'($urandom));
        end
        drain_responses();

        check_value("credit_return pulses", data_t'(credit_pulses), data_t'(req_count));
        check_value("credits at end", data_t'(credits), data_t'(QUEUE_DEPTH));
        check_value("response count", data_t'(rsp_count), data_t'(req_count));
        end_run();
    end

endmodule

/* verilog.f */
src/dma_types_pkg.sv
src/sram_map_pkg.sv
src/dma_req_queue.sv
src/sram_window_decoder.sv
src/sram_responder.sv
src/dma_sram_top.sv
tb/dma_sram_tb.sv
